/* source/addr_cmd_pkg.sv */
`default_nettype none

package addr_cmd_pkg;

	// memory side pin widths
	localparam int MEM_ADDRESS_WIDTH = 14;
	localparam int MEM_BANK_WIDTH = 3;
	localparam int MEM_CHIP_SELECT_WIDTH = 1;

	// a half-rate beat carries two slots, so every field is twice as wide
	localparam int AFI_ADDRESS_WIDTH = 2 * MEM_ADDRESS_WIDTH;
	localparam int AFI_BANK_WIDTH = 2 * MEM_BANK_WIDTH;
	localparam int AFI_RANK_WIDTH = 2 * MEM_CHIP_SELECT_WIDTH;
	localparam int AFI_CONTROL_WIDTH = 2;

	// one slot of each field as seen on the memory pins
	typedef logic [MEM_ADDRESS_WIDTH-1:0] mem_addr_t;
	typedef logic [MEM_BANK_WIDTH-1:0] mem_bank_t;
	typedef logic [MEM_CHIP_SELECT_WIDTH-1:0] mem_rank_t;

	// one beat from the controller, high slot in the upper half
	typedef logic [AFI_ADDRESS_WIDTH-1:0] afi_addr_t;
	typedef logic [AFI_BANK_WIDTH-1:0] afi_bank_t;
	typedef logic [AFI_RANK_WIDTH-1:0] afi_rank_t;
	typedef logic [AFI_CONTROL_WIDTH-1:0] afi_ctl_t;

	// SLOT_LOW marks the sampling edge, SLOT_HIGH the edge between two beats
	typedef enum logic
	{
		SLOT_LOW = 1'b0,
		SLOT_HIGH = 1'b1
	} slot_phase_t;

	// APB register map
	localparam int APB_ADDR_WIDTH = 4;
	localparam int APB_DATA_WIDTH = 32;

	localparam logic [APB_ADDR_WIDTH-1:0] CK_ENABLE_ADDR = 4'h0;

endpackage

`default_nettype wire

/* source/cmd_slot_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_slot_serializer (
	input  logic pll_mem_clk,
	input  logic reset,

	input  addr_cmd_pkg::afi_addr_t phy_ddio_address,
	input  addr_cmd_pkg::afi_bank_t phy_ddio_bank,
	input  addr_cmd_pkg::afi_rank_t phy_ddio_cs_n,
	input  addr_cmd_pkg::afi_rank_t phy_ddio_cke,
	input  addr_cmd_pkg::afi_rank_t phy_ddio_odt,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_ras_n,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_cas_n,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_we_n,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_reset_n,

	output addr_cmd_pkg::mem_addr_t phy_mem_address,
	output addr_cmd_pkg::mem_bank_t phy_mem_bank,
	output addr_cmd_pkg::mem_rank_t phy_mem_cs_n,
	output addr_cmd_pkg::mem_rank_t phy_mem_cke,
	output addr_cmd_pkg::mem_rank_t phy_mem_odt,
	output logic phy_mem_ras_n,
	output logic phy_mem_cas_n,
	output logic phy_mem_we_n,
	output logic phy_mem_reset_n,

	output addr_cmd_pkg::slot_phase_t slot_phase,
	output logic afi_sample
);

	localparam int ADDR_W = addr_cmd_pkg::MEM_ADDRESS_WIDTH;
	localparam int BANK_W = addr_cmd_pkg::MEM_BANK_WIDTH;
	localparam int RANK_W = addr_cmd_pkg::MEM_CHIP_SELECT_WIDTH;

	// beat capture register, holds one beat while its two slots go out
	addr_cmd_pkg::afi_addr_t cap_address;
	addr_cmd_pkg::afi_bank_t cap_bank;
	addr_cmd_pkg::afi_rank_t cap_cs_n;
	addr_cmd_pkg::afi_rank_t cap_cke;
	addr_cmd_pkg::afi_rank_t cap_odt;
	addr_cmd_pkg::afi_ctl_t cap_ras_n;
	addr_cmd_pkg::afi_ctl_t cap_cas_n;
	addr_cmd_pkg::afi_ctl_t cap_we_n;
	addr_cmd_pkg::afi_ctl_t cap_reset_n;

	logic sample_edge;
	logic beat_valid;

	// sampling edges also launch the high slot of the beat taken two edges before
	assign sample_edge = (slot_phase == addr_cmd_pkg::SLOT_LOW);

	always_ff @(posedge pll_mem_clk)
	begin
		if (reset)
		begin
			slot_phase <= addr_cmd_pkg::SLOT_LOW;
			afi_sample <= 1'b0;
			beat_valid <= 1'b0;
		end
		else
		begin
			if (sample_edge)
				slot_phase <= addr_cmd_pkg::SLOT_HIGH;
			else
				slot_phase <= addr_cmd_pkg::SLOT_LOW;
			// flags the cycle whose closing edge samples a beat
			afi_sample <= ~sample_edge;
			if (sample_edge)
				beat_valid <= 1'b1;
		end
	end

	always_ff @(posedge pll_mem_clk)
	begin
		if (sample_edge)
		begin
			cap_address <= phy_ddio_address;
			cap_bank <= phy_ddio_bank;
			cap_cs_n <= phy_ddio_cs_n;
			cap_cke <= phy_ddio_cke;
			cap_odt <= phy_ddio_odt;
			cap_ras_n <= phy_ddio_ras_n;
			cap_cas_n <= phy_ddio_cas_n;
			cap_we_n <= phy_ddio_we_n;
			cap_reset_n <= phy_ddio_reset_n;
		end
	end

	// the held beat drives its low slot first, then its high slot
	always_ff @(posedge pll_mem_clk)
	begin
		if (reset)
		begin
			phy_mem_address <= '0;
			phy_mem_bank <= '0;
			phy_mem_cs_n <= '1;
			phy_mem_cke <= '0;
			phy_mem_odt <= '0;
			phy_mem_ras_n <= 1'b1;
			phy_mem_cas_n <= 1'b1;
			phy_mem_we_n <= 1'b1;
			phy_mem_reset_n <= 1'b1;
		end
		else if (beat_valid)
		begin
			if (sample_edge)
			begin
				phy_mem_address <= cap_address[ADDR_W +: ADDR_W];
				phy_mem_bank <= cap_bank[BANK_W +: BANK_W];
				phy_mem_cs_n <= cap_cs_n[RANK_W +: RANK_W];
				phy_mem_cke <= cap_cke[RANK_W +: RANK_W];
				phy_mem_odt <= cap_odt[RANK_W +: RANK_W];
				phy_mem_ras_n <= cap_ras_n[1];
				phy_mem_cas_n <= cap_cas_n[1];
				phy_mem_we_n <= cap_we_n[1];
				phy_mem_reset_n <= cap_reset_n[1];
			end
			else
			begin
				phy_mem_address <= cap_address[0 +: ADDR_W];
				phy_mem_bank <= cap_bank[0 +: BANK_W];
				phy_mem_cs_n <= cap_cs_n[0 +: RANK_W];
				phy_mem_cke <= cap_cke[0 +: RANK_W];
				phy_mem_odt <= cap_odt[0 +: RANK_W];
				phy_mem_ras_n <= cap_ras_n[0];
				phy_mem_cas_n <= cap_cas_n[0];
				phy_mem_we_n <= cap_we_n[0];
				phy_mem_reset_n <= cap_reset_n[0];
			end
		end
	end

endmodule

`default_nettype wire

/* source/mem_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_clock_gen #(
	parameter int MEM_CK_WIDTH = 2
) (
	input  logic pll_mem_clk,
	input  logic reset,
	input  addr_cmd_pkg::slot_phase_t slot_phase,
	input  logic [MEM_CK_WIDTH-1:0] ck_enable,
	output logic [MEM_CK_WIDTH-1:0] phy_mem_ck,
	output logic [MEM_CK_WIDTH-1:0] phy_mem_ck_n
);

	logic high_slot_next;

	// a sampling edge is the one that puts a high slot on the command bus
	assign high_slot_next = (slot_phase == addr_cmd_pkg::SLOT_LOW);

	genvar i;
	generate
		for (i = 0; i < MEM_CK_WIDTH; i = i + 1)
		begin : g_ck_pair
			logic ck_q;

			always_ff @(posedge pll_mem_clk)
			begin
				if (reset)
					ck_q <= 1'b0;
				else
					ck_q <= high_slot_next & ck_enable[i];
			end

			// true and complement leave from the same flop so they never skew
			assign phy_mem_ck[i] = ck_q;
			assign phy_mem_ck_n[i] = ~ck_q;
		end
	endgenerate

endmodule

`default_nettype wire

/* source/ck_enable_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ck_enable_regs #(
	parameter int MEM_CK_WIDTH = 2
) (
	input  logic pll_mem_clk,
	input  logic reset,

	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [addr_cmd_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input  logic [addr_cmd_pkg::APB_DATA_WIDTH-1:0] pwdata,
	output logic [addr_cmd_pkg::APB_DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,

	output logic [MEM_CK_WIDTH-1:0] ck_enable
);

	logic access;
	logic addr_hit;
	logic [addr_cmd_pkg::APB_DATA_WIDTH-1:0] read_word;

	// the access phase is the second cycle of a transfer
	assign access = psel & penable;
	assign addr_hit = (paddr == addr_cmd_pkg::CK_ENABLE_ADDR);

	always_ff @(posedge pll_mem_clk)
	begin
		if (reset)
			ck_enable <= '0;
		else if (access && pwrite && addr_hit)
			ck_enable <= pwdata[MEM_CK_WIDTH-1:0];
	end

	// only the clock pairs that exist are stored, the rest read back as zero
	always_comb
	begin
		read_word = '0;
		read_word[MEM_CK_WIDTH-1:0] = ck_enable;
	end

	assign prdata = (access && !pwrite && addr_hit) ? read_word : '0;

	// zero wait states, every transfer completes in its first access cycle
	assign pready = 1'b1;
	assign pslverr = access & ~addr_hit;

endmodule

`default_nettype wire

/* source/addr_cmd_pads.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_cmd_pads #(
	parameter int MEM_CK_WIDTH = 2
) (
	input  logic pll_mem_clk,
	input  logic reset,

	// half-rate command beat from the controller
	input  addr_cmd_pkg::afi_addr_t phy_ddio_address,
	input  addr_cmd_pkg::afi_bank_t phy_ddio_bank,
	input  addr_cmd_pkg::afi_rank_t phy_ddio_cs_n,
	input  addr_cmd_pkg::afi_rank_t phy_ddio_cke,
	input  addr_cmd_pkg::afi_rank_t phy_ddio_odt,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_ras_n,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_cas_n,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_we_n,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_reset_n,

	// APB slave
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [addr_cmd_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input  logic [addr_cmd_pkg::APB_DATA_WIDTH-1:0] pwdata,
	output logic [addr_cmd_pkg::APB_DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// memory command pins
	output addr_cmd_pkg::mem_addr_t phy_mem_address,
	output addr_cmd_pkg::mem_bank_t phy_mem_bank,
	output addr_cmd_pkg::mem_rank_t phy_mem_cs_n,
	output addr_cmd_pkg::mem_rank_t phy_mem_cke,
	output addr_cmd_pkg::mem_rank_t phy_mem_odt,
	output logic phy_mem_ras_n,
	output logic phy_mem_cas_n,
	output logic phy_mem_we_n,
	output logic phy_mem_reset_n,

	// memory clock pairs, one per rank
	output logic [MEM_CK_WIDTH-1:0] phy_mem_ck,
	output logic [MEM_CK_WIDTH-1:0] phy_mem_ck_n,

	output logic afi_sample
);

	addr_cmd_pkg::slot_phase_t slot_phase;
	logic [MEM_CK_WIDTH-1:0] ck_enable;

	cmd_slot_serializer u_serializer (
		.pll_mem_clk      (pll_mem_clk),
		.reset            (reset),
		.phy_ddio_address (phy_ddio_address),
		.phy_ddio_bank    (phy_ddio_bank),
		.phy_ddio_cs_n    (phy_ddio_cs_n),
		.phy_ddio_cke     (phy_ddio_cke),
		.phy_ddio_odt     (phy_ddio_odt),
		.phy_ddio_ras_n   (phy_ddio_ras_n),
		.phy_ddio_cas_n   (phy_ddio_cas_n),
		.phy_ddio_we_n    (phy_ddio_we_n),
		.phy_ddio_reset_n (phy_ddio_reset_n),
		.phy_mem_address  (phy_mem_address),
		.phy_mem_bank     (phy_mem_bank),
		.phy_mem_cs_n     (phy_mem_cs_n),
		.phy_mem_cke      (phy_mem_cke),
		.phy_mem_odt      (phy_mem_odt),
		.phy_mem_ras_n    (phy_mem_ras_n),
		.phy_mem_cas_n    (phy_mem_cas_n),
		.phy_mem_we_n     (phy_mem_we_n),
		.phy_mem_reset_n  (phy_mem_reset_n),
		.slot_phase       (slot_phase),
		.afi_sample       (afi_sample)
	);

	mem_clock_gen #(
		.MEM_CK_WIDTH (MEM_CK_WIDTH)
	) u_clock_gen (
		.pll_mem_clk  (pll_mem_clk),
		.reset        (reset),
		.slot_phase   (slot_phase),
		.ck_enable    (ck_enable),
		.phy_mem_ck   (phy_mem_ck),
		.phy_mem_ck_n (phy_mem_ck_n)
	);

	ck_enable_regs #(
		.MEM_CK_WIDTH (MEM_CK_WIDTH)
	) u_regs (
		.pll_mem_clk (pll_mem_clk),
		.reset       (reset),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.ck_enable   (ck_enable)
	);

endmodule

`default_nettype wire

/* verif/addr_cmd_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_cmd_checker #(
	parameter int MEM_CK_WIDTH = 2
) (
	input  logic pll_mem_clk,
	input  logic reset,
	input  addr_cmd_pkg::afi_addr_t phy_ddio_address,
	input  addr_cmd_pkg::afi_bank_t phy_ddio_bank,
	input  addr_cmd_pkg::afi_rank_t phy_ddio_cs_n,
	input  addr_cmd_pkg::afi_rank_t phy_ddio_cke,
	input  addr_cmd_pkg::afi_rank_t phy_ddio_odt,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_ras_n,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_cas_n,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_we_n,
	input  addr_cmd_pkg::afi_ctl_t phy_ddio_reset_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [addr_cmd_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input  logic [addr_cmd_pkg::APB_DATA_WIDTH-1:0] pwdata,
	input  logic [addr_cmd_pkg::APB_DATA_WIDTH-1:0] prdata,
	input  logic pready,
	input  logic pslverr,
	input  addr_cmd_pkg::mem_addr_t phy_mem_address,
	input  addr_cmd_pkg::mem_bank_t phy_mem_bank,
	input  addr_cmd_pkg::mem_rank_t phy_mem_cs_n,
	input  addr_cmd_pkg::mem_rank_t phy_mem_cke,
	input  addr_cmd_pkg::mem_rank_t phy_mem_odt,
	input  logic phy_mem_ras_n,
	input  logic phy_mem_cas_n,
	input  logic phy_mem_we_n,
	input  logic phy_mem_reset_n,
	input  logic [MEM_CK_WIDTH-1:0] phy_mem_ck,
	input  logic [MEM_CK_WIDTH-1:0] phy_mem_ck_n,
	input  logic afi_sample,
	// expected APB response from the stimulus file, valid while apb_check is high
	input  logic apb_check,
	input  logic [31:0] exp_rdata,
	input  logic exp_slverr,
	output int error_count,
	output int check_count
);

	int errors = 0;
	int checks = 0;
	bit model_valid = 1'b0;
	bit phase_high = 1'b0;

	// beats as {address, bank, cs_n, cke, odt, ras_n, cas_n, we_n, reset_n}
	logic [47:0] beats[$];

	addr_cmd_pkg::mem_addr_t exp_address;
	addr_cmd_pkg::mem_bank_t exp_bank;
	addr_cmd_pkg::mem_rank_t exp_cs_n;
	addr_cmd_pkg::mem_rank_t exp_cke;
	addr_cmd_pkg::mem_rank_t exp_odt;
	logic exp_ras_n;
	logic exp_cas_n;
	logic exp_we_n;
	logic exp_reset_n;
	logic exp_sample;
	logic [MEM_CK_WIDTH-1:0] exp_ck;
	logic [MEM_CK_WIDTH-1:0] exp_ck_n;
	logic [MEM_CK_WIDTH-1:0] ck_en_model;

	// APB response seen in an access cycle, compared at the following falling edge
	bit apb_seen = 1'b0;
	logic seen_read;
	logic seen_pready;
	logic seen_slverr;
	logic [31:0] seen_rdata;
	logic want_slverr;
	logic [31:0] want_rdata;

	assign error_count = errors;
	assign check_count = checks;

	// hi selects the upper slot of every field, one bit per rank here
	task automatic expect_slot(input logic [47:0] beat, input int hi);
		exp_address = beat[20 + 14 * hi +: 14];
		exp_bank = beat[14 + 3 * hi +: 3];
		exp_cs_n = beat[12 + hi];
		exp_cke = beat[10 + hi];
		exp_odt = beat[8 + hi];
		exp_ras_n = beat[6 + hi];
		exp_cas_n = beat[4 + hi];
		exp_we_n = beat[2 + hi];
		exp_reset_n = beat[hi];
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	always @(posedge pll_mem_clk)
	begin
		apb_seen = psel && penable && apb_check;
		if (apb_seen)
		begin
			seen_read = !pwrite;
			seen_pready = pready;
			seen_slverr = pslverr;
			seen_rdata = prdata;
			want_slverr = exp_slverr;
			want_rdata = exp_rdata;
		end
		if (reset)
		begin
			model_valid = 1'b1;
			phase_high = 1'b0;
			beats.delete();
			exp_address = '0;
			exp_bank = '0;
			exp_cs_n = '1;
			exp_cke = '0;
			exp_odt = '0;
			exp_ras_n = 1'b1;
			exp_cas_n = 1'b1;
			exp_we_n = 1'b1;
			exp_reset_n = 1'b1;
			exp_sample = 1'b0;
			exp_ck = '0;
			ck_en_model = '0;
		end
		else
		begin
			if (!phase_high)
			begin
				// sampling edge: the held beat moves to its high slot, a new one is taken
				if (beats.size() > 0)
					expect_slot(beats.pop_front(), 1);
				beats.push_back({phy_ddio_address, phy_ddio_bank, phy_ddio_cs_n,
					phy_ddio_cke, phy_ddio_odt, phy_ddio_ras_n, phy_ddio_cas_n,
					phy_ddio_we_n, phy_ddio_reset_n});
				exp_ck = ck_en_model;
				exp_sample = 1'b0;
			end
			else
			begin
				expect_slot(beats[0], 0);
				exp_ck = '0;
				exp_sample = 1'b1;
			end
			phase_high = !phase_high;
			if (psel && penable && pwrite && paddr == addr_cmd_pkg::CK_ENABLE_ADDR)
				ck_en_model = pwdata[MEM_CK_WIDTH-1:0];
		end
		exp_ck_n = ~exp_ck;
	end

	always @(negedge pll_mem_clk)
	begin
		if (model_valid)
		begin
			compare_value("phy_mem_address", 32'(exp_address), 32'(phy_mem_address));
			compare_value("phy_mem_bank", 32'(exp_bank), 32'(phy_mem_bank));
			compare_value("phy_mem_cs_n", 32'(exp_cs_n), 32'(phy_mem_cs_n));
			compare_value("phy_mem_cke", 32'(exp_cke), 32'(phy_mem_cke));
			compare_value("phy_mem_odt", 32'(exp_odt), 32'(phy_mem_odt));
			compare_value("phy_mem_ras_n", 32'(exp_ras_n), 32'(phy_mem_ras_n));
			compare_value("phy_mem_cas_n", 32'(exp_cas_n), 32'(phy_mem_cas_n));
			compare_value("phy_mem_we_n", 32'(exp_we_n), 32'(phy_mem_we_n));
			compare_value("phy_mem_reset_n", 32'(exp_reset_n), 32'(phy_mem_reset_n));
			compare_value("phy_mem_ck", 32'(exp_ck), 32'(phy_mem_ck));
			compare_value("phy_mem_ck_n", 32'(exp_ck_n), 32'(phy_mem_ck_n));
			compare_value("afi_sample", 32'(exp_sample), 32'(afi_sample));
		end
		if (apb_seen)
		begin
			compare_value("pready", 32'h1, 32'(seen_pready));
			compare_value("pslverr", 32'(want_slverr), 32'(seen_slverr));
			if (seen_read)
				compare_value("prdata", want_rdata, seen_rdata);
		end
	end

endmodule

`default_nettype wire

/* verif/tb_addr_cmd_pads.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_addr_cmd_pads;

	localparam int CK_W = 2;
	localparam string STIM_FILE = "verif/addr_cmd_stim.txt";

	logic pll_mem_clk;
	logic reset;
	addr_cmd_pkg::afi_addr_t phy_ddio_address;
	addr_cmd_pkg::afi_bank_t phy_ddio_bank;
	addr_cmd_pkg::afi_rank_t phy_ddio_cs_n;
	addr_cmd_pkg::afi_rank_t phy_ddio_cke;
	addr_cmd_pkg::afi_rank_t phy_ddio_odt;
	addr_cmd_pkg::afi_ctl_t phy_ddio_ras_n;
	addr_cmd_pkg::afi_ctl_t phy_ddio_cas_n;
	addr_cmd_pkg::afi_ctl_t phy_ddio_we_n;
	addr_cmd_pkg::afi_ctl_t phy_ddio_reset_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [addr_cmd_pkg::APB_ADDR_WIDTH-1:0] paddr;
	logic [addr_cmd_pkg::APB_DATA_WIDTH-1:0] pwdata;
	logic [addr_cmd_pkg::APB_DATA_WIDTH-1:0] prdata;
	logic pready;
	logic pslverr;
	addr_cmd_pkg::mem_addr_t phy_mem_address;
	addr_cmd_pkg::mem_bank_t phy_mem_bank;
	addr_cmd_pkg::mem_rank_t phy_mem_cs_n;
	addr_cmd_pkg::mem_rank_t phy_mem_cke;
	addr_cmd_pkg::mem_rank_t phy_mem_odt;
	logic phy_mem_ras_n;
	logic phy_mem_cas_n;
	logic phy_mem_we_n;
	logic phy_mem_reset_n;
	logic [CK_W-1:0] phy_mem_ck;
	logic [CK_W-1:0] phy_mem_ck_n;
	logic afi_sample;

	logic apb_check;
	logic [31:0] exp_rdata;
	logic exp_slverr;
	int error_count;
	int check_count;
	int other_errors;
	logic [31:0] lcg_state;
	string lines[$];
	bit lines_loaded;

	addr_cmd_pads #(.MEM_CK_WIDTH(CK_W)) dut_i (.*);

	addr_cmd_checker #(.MEM_CK_WIDTH(CK_W)) checker_i (.*);

	initial pll_mem_clk = 1'b0;
	always #5 pll_mem_clk = ~pll_mem_clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// the upper LCG bits have the longer period, so the fields come from there
	task automatic random_beat();
		lcg_state = lcg_next(lcg_state);
		phy_ddio_address = lcg_state[31:4];
		lcg_state = lcg_next(lcg_state);
		phy_ddio_bank = lcg_state[31:26];
		phy_ddio_cs_n = lcg_state[25:24];
		phy_ddio_cke = lcg_state[23:22];
		phy_ddio_odt = lcg_state[21:20];
		phy_ddio_ras_n = lcg_state[19:18];
		phy_ddio_cas_n = lcg_state[17:16];
		phy_ddio_we_n = lcg_state[15:14];
		phy_ddio_reset_n = lcg_state[13:12];
	endtask

	// returns at the falling edge of a cycle whose closing edge samples a beat
	task automatic wait_sample_window();
		@(negedge pll_mem_clk);
		while (afi_sample !== 1'b1)
			@(negedge pll_mem_clk);
	endtask

	task automatic apb_transfer(input logic is_write, input logic [3:0] addr,
		input logic [31:0] data, input logic slverr);
		@(negedge pll_mem_clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = is_write;
		paddr = addr;
		pwdata = is_write ? data : 32'h0;
		@(negedge pll_mem_clk);
		penable = 1'b1;
		apb_check = 1'b1;
		exp_rdata = is_write ? 32'h0 : data;
		exp_slverr = slverr;
		@(posedge pll_mem_clk);
		while (pready !== 1'b1)
			@(posedge pll_mem_clk);
		@(negedge pll_mem_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		apb_check = 1'b0;
	endtask

	task automatic bad_line(input string line);
		other_errors++;
		$display("stimulus line not understood: %s", line);
	endtask

	task automatic run_line(input string line);
		logic [31:0] f[9];
		string rest;
		int n;
		rest = line.substr(1, line.len() - 1);
		case (line.getc(0))
			"B":
			begin
				n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
				if (n != 9)
					bad_line(line);
				else
				begin
					wait_sample_window();
					phy_ddio_address = f[0][27:0];
					phy_ddio_bank = f[1][5:0];
					phy_ddio_cs_n = f[2][1:0];
					phy_ddio_cke = f[3][1:0];
					phy_ddio_odt = f[4][1:0];
					phy_ddio_ras_n = f[5][1:0];
					phy_ddio_cas_n = f[6][1:0];
					phy_ddio_we_n = f[7][1:0];
					phy_ddio_reset_n = f[8][1:0];
				end
			end
			"W", "R":
			begin
				n = $sscanf(rest, "%h %h %h", f[0], f[1], f[2]);
				if (n != 3)
					bad_line(line);
				else
					apb_transfer(line.getc(0) == "W", f[0][3:0], f[1], f[2][0]);
			end
			"I":
			begin
				n = $sscanf(rest, "%d", f[0]);
				if (n != 1)
					bad_line(line);
				else
				begin
					repeat (f[0])
					begin
						wait_sample_window();
						random_beat();
					end
				end
			end
			default:
				bad_line(line);
		endcase
	endtask

	// watchdog, sized from the number of stimulus lines
	initial
	begin
		wait (lines_loaded);
		repeat ((lines.size() + 100) * 20) @(posedge pll_mem_clk);
		$display("timeout: stimulus did not finish within %0d cycles",
			(lines.size() + 100) * 20);
		$display("summary: %0d checks, %0d value mismatches, %0d other errors",
			check_count, error_count, other_errors + 1);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		int fd;
		int rc;
		string line;
		reset = 1'b1;
		phy_ddio_address = '0;
		phy_ddio_bank = '0;
		phy_ddio_cs_n = '1;
		phy_ddio_cke = '0;
		phy_ddio_odt = '0;
		phy_ddio_ras_n = '1;
		phy_ddio_cas_n = '1;
		phy_ddio_we_n = '1;
		phy_ddio_reset_n = '1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		apb_check = 1'b0;
		exp_rdata = '0;
		exp_slverr = 1'b0;
		other_errors = 0;
		lcg_state = 32'd49;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			other_errors++;
			$display("could not open stimulus file %s", STIM_FILE);
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				rc = $fgets(line, fd);
				if (rc > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
					lines.push_back(line);
			end
			$fclose(fd);
		end
		if (lines.size() == 0)
		begin
			other_errors++;
			$display("no stimulus lines were read");
		end
		lines_loaded = 1'b1;
		repeat (5) @(negedge pll_mem_clk);
		reset = 1'b0;
		foreach (lines[i])
			run_line(lines[i]);
		repeat (6) @(negedge pll_mem_clk);
		if (check_count == 0)
		begin
			other_errors++;
			$display("the checker never compared an output");
		end
		$display("summary: %0d checks, %0d value mismatches, %0d other errors",
			check_count, error_count, other_errors);
		if (error_count == 0 && other_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/addr_cmd_stim.txt */
# B address bank cs_n cke odt ras_n cas_n we_n reset_n : one beat in hex, high slot in upper half
# W paddr pwdata pslverr | R paddr prdata pslverr | I count : random idle beats
I 3
B 0a5f3c1 2c 2 3 0 2 1 3 3
B 1234567 15 1 3 1 1 2 0 3
B fffffff 3f 0 3 3 0 0 0 3
B 0000000 00 3 0 0 3 3 3 0
B 5555aaa 2a 2 1 2 1 1 2 1
I 4
W 0 fffffffe 0
R 0 00000002 0
I 6
W 0 00000005 0
R 0 00000001 0
B 3c3c3c3 0f 1 3 2 2 0 1 3
B 0c0ffee 33 2 3 1 0 2 2 3
I 4
W 4 00000003 1
R 8 00000000 1
R 0 00000001 0
W c ffffffff 1
R 0 00000001 0
W 0 00000003 0
R 0 00000003 0
B 7a7a7a7 21 0 3 3 3 1 0 3
B 0123456 12 3 2 1 0 3 1 2
B 1111111 3e 2 3 0 1 1 1 3
I 6
W 0 00000000 0
R 0 00000000 0
I 4

/* files.f */
source/addr_cmd_pkg.sv
source/cmd_slot_serializer.sv
source/mem_clock_gen.sv
source/ck_enable_regs.sv
source/addr_cmd_pads.sv
verif/addr_cmd_checker.sv
verif/tb_addr_cmd_pads.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f files.f --top-module tb_addr_cmd_pads -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
